// File: src/vrf_pkg.sv
//////////////////////////////
// VRF lane package
// Widths, element and address types, command and bank payload structs
// and the operand requester state encoding
//////////////////////////////

package vrf_pkg;

  // Element, address and bookkeeping widths
  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned AddrWidth    = 6;
  localparam int unsigned VlenWidth    = 6;
  localparam int unsigned VidWidth     = 2;
  localparam int unsigned QueueIdWidth = 1;

  // One written-last-cycle bit per instruction id
  localparam int unsigned NrVids = 1 << VidWidth;

  typedef logic [ElemWidth-1:0]    elem_t;
  typedef logic [AddrWidth-1:0]    vrf_addr_t;
  typedef logic [VlenWidth-1:0]    vlen_t;
  typedef logic [VidWidth-1:0]     vid_t;
  typedef logic [QueueIdWidth-1:0] queue_id_t;

  // Read command for one operand requester
  typedef struct packed {
    vrf_addr_t base;
    vlen_t     len;
    logic      hazard;
    vid_t      vid;
  } operand_cmd_t;

  // Result coming back from a functional unit
  typedef struct packed {
    vid_t      id;
    vrf_addr_t addr;
    elem_t     data;
  } result_t;

  // What a master offers to a bank arbiter
  // Row keeps the full address width, upper bits stay zero
  typedef struct packed {
    vrf_addr_t row;
    logic      wen;
    elem_t     wdata;
    queue_id_t queue;
  } bank_req_t;

  typedef enum logic [1:0] {
    IDLE,
    REQUESTING,
    DONE_WAIT
  } req_state_e;

endpackage

// File: src/vrf_bank_arbiter.sv
//////////////////////////////
// VRF bank arbiter
// Round-robin pick of one master per cycle for a single bank,
// forwards the winner's payload
//////////////////////////////

`timescale 1ns/100ps

module vrf_bank_arbiter #(
  parameter int unsigned NrMasters = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic               [NrMasters-1:0]  req_i,
  input  vrf_pkg::bank_req_t [NrMasters-1:0]  payload_i,
  output logic               [NrMasters-1:0]  gnt_o,
  output logic                                valid_o,
  output vrf_pkg::bank_req_t                  payload_o
);

  import vrf_pkg::*;

  localparam int unsigned IdxWidth = (NrMasters > 1) ? $clog2(NrMasters) : 1;

  typedef logic [IdxWidth-1:0] idx_t;

  idx_t ptr_q;
  idx_t win;
  logic found;

  // First requester at or after the pointer wins
  always_comb begin
    found = 1'b0;
    win   = ptr_q;
    for (int i = 0; i < int'(NrMasters); i++) begin
      if (!found && req_i[(int'(ptr_q) + i) % int'(NrMasters)]) begin
        found = 1'b1;
        win   = idx_t'((int'(ptr_q) + i) % int'(NrMasters));
      end
    end
  end

  always_comb begin
    gnt_o      = '0;
    gnt_o[win] = found;
  end

  // The bank takes every grant at once
  assign valid_o   = found;
  assign payload_o = payload_i[win];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= (win == idx_t'(NrMasters - 1)) ? '0 : win + 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_o))
    else $error("bank arbiter granted more than one master");

endmodule

// File: src/operand_requester.sv
//////////////////////////////
// Operand requester
// Takes read commands over four-phase req/ack and walks the operand
// one element per grant, stalled by credits and write hazards
//////////////////////////////

`timescale 1ns/100ps

module operand_requester #(
  parameter int unsigned        NrBanks    = 4,
  parameter int unsigned        QueueDepth = 4,
  parameter vrf_pkg::queue_id_t QueueId    = '0
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cmd_req_i,
  input  vrf_pkg::operand_cmd_t         cmd_i,
  output logic                          cmd_ack_o,
  input  logic [vrf_pkg::NrVids-1:0]    written_i,
  output logic [NrBanks-1:0]            bank_req_o,
  output vrf_pkg::bank_req_t            payload_o,
  input  logic [NrBanks-1:0]            gnt_i,
  input  logic                          pop_i
);

  import vrf_pkg::*;

  localparam int unsigned BankBits    = $clog2(NrBanks);
  localparam int unsigned CreditWidth = $clog2(QueueDepth + 1);

  typedef logic [CreditWidth-1:0] credit_t;

  req_state_e state_q, state_d;
  vrf_addr_t  addr_q, addr_d;
  vlen_t      len_q, len_d;
  logic       hazard_q, hazard_d;
  vid_t       vid_q, vid_d;
  logic       ack_q, ack_d;
  credit_t    credit_q, credit_d;

  logic granted;
  logic credit_ok;
  logic hazard_ok;
  logic issue;

  assign granted   = |gnt_i;
  // Words in flight plus words in the queue must stay below the depth
  assign credit_ok = credit_q < credit_t'(QueueDepth);
  // A dependent read only follows a write of its id from last cycle
  assign hazard_ok = !hazard_q || written_i[vid_q];
  assign issue     = (state_q == REQUESTING) && credit_ok && hazard_ok;

  // Interleaved banks, low address bits pick the bank
  always_comb begin
    bank_req_o                       = '0;
    bank_req_o[addr_q[BankBits-1:0]] = issue;
  end

  assign payload_o = '{
    row:   vrf_addr_t'(addr_q >> BankBits),
    wen:   1'b0,
    wdata: '0,
    queue: QueueId
  };

  assign cmd_ack_o = ack_q;

  always_comb begin
    credit_d = credit_q;
    if (granted && !pop_i) begin
      credit_d = credit_q + 1'b1;
    end else if (!granted && pop_i) begin
      credit_d = credit_q - 1'b1;
    end
  end

  always_comb begin
    state_d  = state_q;
    addr_d   = addr_q;
    len_d    = len_q;
    hazard_d = hazard_q;
    vid_d    = vid_q;
    ack_d    = ack_q;

    // Ack follows req down one cycle later
    if (!cmd_req_i) begin
      ack_d = 1'b0;
    end

    case (state_q)
      IDLE: begin
        if (cmd_req_i && !ack_q) begin
          state_d  = REQUESTING;
          addr_d   = cmd_i.base;
          len_d    = cmd_i.len;
          hazard_d = cmd_i.hazard;
          vid_d    = cmd_i.vid;
          ack_d    = 1'b1;
        end
      end
      REQUESTING: begin
        if (granted) begin
          addr_d = addr_q + 1'b1;
          len_d  = len_q - 1'b1;
          if (len_q == vlen_t'(1)) begin
            state_d = DONE_WAIT;
          end
        end
      end
      DONE_WAIT: begin
        // Hold off a new command until the source has dropped req
        if (!cmd_req_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      len_q    <= '0;
      hazard_q <= 1'b0;
      ack_q    <= 1'b0;
      credit_q <= '0;
    end else begin
      state_q  <= state_d;
      len_q    <= len_d;
      hazard_q <= hazard_d;
      ack_q    <= ack_d;
      credit_q <= credit_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    vid_q  <= vid_d;
  end

  // Grants come from the bank arbiters, which must only answer requests
  assert property (@(posedge clk_i) disable iff (!rst_ni) (gnt_i & ~bank_req_o) == '0)
    else $error("operand requester granted without a request");

  assert property (@(posedge clk_i) disable iff (!rst_ni) credit_q <= credit_t'(QueueDepth))
    else $error("operand requester credit above queue depth");

endmodule

// File: src/result_write_port.sv
//////////////////////////////
// Result write port
// Four-phase req/ack front end that turns one result into a bank write
//////////////////////////////

`timescale 1ns/100ps

module result_write_port #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      wr_req_i,
  input  vrf_pkg::result_t          wr_i,
  output logic                      wr_ack_o,
  output logic [NrBanks-1:0]        bank_req_o,
  output vrf_pkg::bank_req_t        payload_o,
  input  logic [NrBanks-1:0]        gnt_i,
  output logic                      granted_o,
  output vrf_pkg::vid_t             granted_id_o
);

  import vrf_pkg::*;

  localparam int unsigned BankBits = $clog2(NrBanks);

  // WR_OPEN is idle with req low and waiting for a grant with req high
  typedef enum logic {
    WR_OPEN,
    WR_ACKED
  } wr_state_e;

  wr_state_e state_q, state_d;

  always_comb begin
    bank_req_o = '0;
    if (wr_req_i && (state_q == WR_OPEN)) begin
      bank_req_o[wr_i.addr[BankBits-1:0]] = 1'b1;
    end
  end

  assign payload_o = '{
    row:   vrf_addr_t'(wr_i.addr >> BankBits),
    wen:   1'b1,
    wdata: wr_i.data,
    queue: '0
  };

  // Grant cycle is the write cycle
  assign granted_o    = |gnt_i;
  assign granted_id_o = wr_i.id;
  assign wr_ack_o     = (state_q == WR_ACKED);

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_OPEN:  if (granted_o) state_d = WR_ACKED;
      WR_ACKED: if (!wr_req_i) state_d = WR_OPEN;
      default:  state_d = WR_OPEN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WR_OPEN;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: src/vrf_banks.sv
//////////////////////////////
// VRF banks
// Single-port word banks, granted reads come back one cycle later
// tagged with their operand queue
//////////////////////////////

`timescale 1ns/100ps

module vrf_banks #(
  parameter int unsigned NrBanks  = 4,
  parameter int unsigned NrQueues = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic               [NrBanks-1:0]    valid_i,
  input  vrf_pkg::bank_req_t [NrBanks-1:0]    payload_i,
  output logic               [NrQueues-1:0]   rdata_valid_o,
  output vrf_pkg::elem_t     [NrQueues-1:0]   rdata_o
);

  import vrf_pkg::*;

  localparam int unsigned RowsPerBank = (1 << AddrWidth) / NrBanks;
  localparam int unsigned RowBits     = $clog2(RowsPerBank);

  logic      [NrBanks-1:0]               bank_rd_valid;
  queue_id_t [NrBanks-1:0]               bank_rd_queue;
  elem_t     [NrBanks-1:0]               bank_rd_data;
  logic      [NrQueues-1:0][NrBanks-1:0] hit;

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    elem_t              mem_q [RowsPerBank];
    logic [RowBits-1:0] row;
    logic               rd_valid_q;
    queue_id_t          rd_queue_q;
    elem_t              rd_data_q;

    assign row = payload_i[b].row[RowBits-1:0];

    always_ff @(posedge clk_i) begin
      if (valid_i[b] && payload_i[b].wen) begin
        mem_q[row] <= payload_i[b].wdata;
      end
      if (valid_i[b] && !payload_i[b].wen) begin
        rd_data_q  <= mem_q[row];
        rd_queue_q <= payload_i[b].queue;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rd_valid_q <= 1'b0;
      end else begin
        rd_valid_q <= valid_i[b] && !payload_i[b].wen;
      end
    end

    assign bank_rd_valid[b] = rd_valid_q;
    assign bank_rd_queue[b] = rd_queue_q;
    assign bank_rd_data[b]  = rd_data_q;
  end

  // Route each bank's read data to the queue in its tag
  always_comb begin
    rdata_valid_o = '0;
    rdata_o       = '0;
    for (int q = 0; q < int'(NrQueues); q++) begin
      for (int b = 0; b < int'(NrBanks); b++) begin
        hit[q][b] = bank_rd_valid[b] && (bank_rd_queue[b] == queue_id_t'(q));
        if (hit[q][b]) begin
          rdata_valid_o[q] = 1'b1;
          rdata_o[q]       = bank_rd_data[b];
        end
      end
    end
  end

  // Holds since each requester asks one bank per cycle
  for (genvar q = 0; q < NrQueues; q++) begin : gen_route_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit[q]))
      else $error("two banks returned data to queue %0d", q);
  end

endmodule

// File: src/operand_queue.sv
//////////////////////////////
// Operand queue
// Small FIFO from VRF read data to the lane operand output
//////////////////////////////

`timescale 1ns/100ps

module operand_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           push_i,
  input  vrf_pkg::elem_t data_i,
  output logic           valid_o,
  output vrf_pkg::elem_t data_o,
  input  logic           pop_i
);

  import vrf_pkg::*;

  localparam int unsigned PtrBits   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CountBits = $clog2(QueueDepth + 1);

  typedef logic [PtrBits-1:0]   ptr_t;
  typedef logic [CountBits-1:0] count_t;

  elem_t  mem_q [QueueDepth];
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  count_t count_q;
  logic   full;
  logic   do_push;
  logic   do_pop;

  // Wraps at the depth, which need not be a power of two
  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == ptr_t'(QueueDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full    = (count_q == count_t'(QueueDepth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!do_push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Requester credits should keep this from ever firing
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full))
    else $error("operand queue pushed while full");

endmodule

// File: src/vrf_lane_top.sv
//////////////////////////////
// VRF lane top
// Operand requesters and result write ports sharing the banks
// through one round-robin arbiter per bank
//////////////////////////////

`timescale 1ns/100ps

module vrf_lane_top #(
  parameter int unsigned NrBanks    = 4,
  parameter int unsigned NrQueues   = 2,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                  [NrQueues-1:0]   cmd_req_i,
  input  vrf_pkg::operand_cmd_t [NrQueues-1:0]   cmd_i,
  output logic                  [NrQueues-1:0]   cmd_ack_o,
  input  logic                                   alu_wr_req_i,
  input  vrf_pkg::result_t                       alu_wr_i,
  output logic                                   alu_wr_ack_o,
  input  logic                                   ldu_wr_req_i,
  input  vrf_pkg::result_t                       ldu_wr_i,
  output logic                                   ldu_wr_ack_o,
  output logic                  [NrQueues-1:0]   op_valid_o,
  output vrf_pkg::elem_t        [NrQueues-1:0]   op_data_o,
  input  logic                  [NrQueues-1:0]   op_pop_i
);

  import vrf_pkg::*;

  localparam int unsigned NrWritePorts = 2;
  // Masters 0..NrQueues-1 are requesters, then alu and ldu
  localparam int unsigned NrMasters    = NrQueues + NrWritePorts;

  logic      [NrMasters-1:0][NrBanks-1:0] mst_req;
  logic      [NrMasters-1:0][NrBanks-1:0] mst_gnt;
  bank_req_t [NrMasters-1:0]              mst_payload;
  logic      [NrBanks-1:0][NrMasters-1:0] arb_req;
  logic      [NrBanks-1:0][NrMasters-1:0] arb_gnt;
  logic      [NrBanks-1:0]                bank_valid;
  bank_req_t [NrBanks-1:0]                bank_payload;
  logic      [NrQueues-1:0]               rdata_valid;
  elem_t     [NrQueues-1:0]               rdata;

  logic    [NrWritePorts-1:0] wp_req;
  logic    [NrWritePorts-1:0] wp_ack;
  logic    [NrWritePorts-1:0] wp_granted;
  result_t [NrWritePorts-1:0] wp_data;
  vid_t    [NrWritePorts-1:0] wp_id;
  logic    [NrVids-1:0]       written_d, written_q;

  assign wp_req       = {ldu_wr_req_i, alu_wr_req_i};
  assign wp_data      = {ldu_wr_i, alu_wr_i};
  assign alu_wr_ack_o = wp_ack[0];
  assign ldu_wr_ack_o = wp_ack[1];

  // Master-major requests to bank-major arbiter inputs and back
  for (genvar b = 0; b < NrBanks; b++) begin : gen_xpose_bank
    for (genvar m = 0; m < NrMasters; m++) begin : gen_xpose_mst
      assign arb_req[b][m] = mst_req[m][b];
      assign mst_gnt[m][b] = arb_gnt[b][m];
    end
  end

  for (genvar q = 0; q < NrQueues; q++) begin : gen_queue
    operand_requester #(
      .NrBanks    (NrBanks),
      .QueueDepth (QueueDepth),
      .QueueId    (queue_id_t'(q))
    ) operand_requester_inst (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .cmd_req_i  (cmd_req_i[q]),
      .cmd_i      (cmd_i[q]),
      .cmd_ack_o  (cmd_ack_o[q]),
      .written_i  (written_q),
      .bank_req_o (mst_req[q]),
      .payload_o  (mst_payload[q]),
      .gnt_i      (mst_gnt[q]),
      .pop_i      (op_pop_i[q] && op_valid_o[q])
    );

    operand_queue #(
      .QueueDepth (QueueDepth)
    ) operand_queue_inst (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .push_i  (rdata_valid[q]),
      .data_i  (rdata[q]),
      .valid_o (op_valid_o[q]),
      .data_o  (op_data_o[q]),
      .pop_i   (op_pop_i[q])
    );
  end

  for (genvar w = 0; w < NrWritePorts; w++) begin : gen_wport
    result_write_port #(
      .NrBanks (NrBanks)
    ) result_write_port_inst (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .wr_req_i     (wp_req[w]),
      .wr_i         (wp_data[w]),
      .wr_ack_o     (wp_ack[w]),
      .bank_req_o   (mst_req[NrQueues + w]),
      .payload_o    (mst_payload[NrQueues + w]),
      .gnt_i        (mst_gnt[NrQueues + w]),
      .granted_o    (wp_granted[w]),
      .granted_id_o (wp_id[w])
    );
  end

  for (genvar b = 0; b < NrBanks; b++) begin : gen_arb
    vrf_bank_arbiter #(
      .NrMasters (NrMasters)
    ) vrf_bank_arbiter_inst (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .req_i     (arb_req[b]),
      .payload_i (mst_payload),
      .gnt_o     (arb_gnt[b]),
      .valid_o   (bank_valid[b]),
      .payload_o (bank_payload[b])
    );
  end

  vrf_banks #(
    .NrBanks  (NrBanks),
    .NrQueues (NrQueues)
  ) vrf_banks_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (bank_valid),
    .payload_i     (bank_payload),
    .rdata_valid_o (rdata_valid),
    .rdata_o       (rdata)
  );

  // Written-last-cycle vector, paces dependent reads
  always_comb begin
    written_d = '0;
    for (int w = 0; w < int'(NrWritePorts); w++) begin
      if (wp_granted[w]) begin
        written_d[wp_id[w]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_q <= '0;
    end else begin
      written_q <= written_d;
    end
  end

endmodule

// File: testbench/tb_vrf_lane_top.sv
//////////////////////////////
// VRF lane testbench
// Random reads and writes checked against a word model of the
// register file and one expected-data FIFO per operand queue
//////////////////////////////

`timescale 1ns/100ps

module tb_vrf_lane_top;

  import vrf_pkg::*;

  localparam int unsigned NrBanks    = 4;
  localparam int unsigned NrQueues   = 2;
  localparam int unsigned QueueDepth = 4;
  localparam int          Timeout    = 400;
  localparam int          ExpSize    = 256;

  logic                        clk_i;
  logic                        rst_ni;
  logic         [NrQueues-1:0] cmd_req_i;
  operand_cmd_t [NrQueues-1:0] cmd_i;
  logic         [NrQueues-1:0] cmd_ack_o;
  logic                        alu_wr_req_i;
  result_t                     alu_wr_i;
  logic                        alu_wr_ack_o;
  logic                        ldu_wr_req_i;
  result_t                     ldu_wr_i;
  logic                        ldu_wr_ack_o;
  logic         [NrQueues-1:0] op_valid_o;
  elem_t        [NrQueues-1:0] op_data_o;
  logic         [NrQueues-1:0] op_pop_i = '0;

  integer seed = 27842;
  int     value_errors;
  int     timeout_errors;

  // Register file model and the values a dependent read must see
  elem_t model_mem [64];
  elem_t fresh [64];
  elem_t exp_data [NrQueues][ExpSize];
  int    exp_wr [NrQueues];
  int    exp_rd [NrQueues];
  int    pop_pct [NrQueues];
  logic  [NrQueues-1:0] pop_hold;

  vrf_lane_top #(
    .NrBanks    (NrBanks),
    .NrQueues   (NrQueues),
    .QueueDepth (QueueDepth)
  ) vrf_lane_top_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_req_i    (cmd_req_i),
    .cmd_i        (cmd_i),
    .cmd_ack_o    (cmd_ack_o),
    .alu_wr_req_i (alu_wr_req_i),
    .alu_wr_i     (alu_wr_i),
    .alu_wr_ack_o (alu_wr_ack_o),
    .ldu_wr_req_i (ldu_wr_req_i),
    .ldu_wr_i     (ldu_wr_i),
    .ldu_wr_ack_o (ldu_wr_ack_o),
    .op_valid_o   (op_valid_o),
    .op_data_o    (op_data_o),
    .op_pop_i     (op_pop_i)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  task automatic check(input string name, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      value_errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic timed_out(input string what);
    timeout_errors++;
    $display("Gave up waiting for %s at %0t", what, $time);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic elem_t rand_word();
    return elem_t'($random(seed));
  endfunction

  function automatic logic wr_ack(input int port);
    return (port == 0) ? alu_wr_ack_o : ldu_wr_ack_o;
  endfunction

  task automatic set_write(input int port, input logic req, input result_t res);
    if (port == 0) begin
      alu_wr_req_i = req;
      alu_wr_i     = res;
    end else begin
      ldu_wr_req_i = req;
      ldu_wr_i     = res;
    end
  endtask

  // Four-phase read command that queues its expected words at the ack
  task automatic read_cmd(input int q, input vrf_addr_t base, input vlen_t len,
                          input logic hazard, input vid_t vid);
    int           cnt;
    logic         acked;
    operand_cmd_t cmd;
    cmd.base   = base;
    cmd.len    = len;
    cmd.hazard = hazard;
    cmd.vid    = vid;
    next_cycle();
    cmd_i[q]     = cmd;
    cmd_req_i[q] = 1'b1;
    cnt = 0;
    do begin
      next_cycle();
      cnt++;
    end while (!cmd_ack_o[q] && cnt < Timeout);
    acked = cmd_ack_o[q];
    if (acked) begin
      check("cmd_ack_o latency", 1, cnt);
      for (int i = 0; i < int'(len); i++) begin
        exp_data[q][exp_wr[q] % ExpSize] = hazard ? fresh[vrf_addr_t'(base + i)]
                                                  : model_mem[vrf_addr_t'(base + i)];
        exp_wr[q]++;
      end
      // Ack must hold while req is still high
      next_cycle();
      check("cmd_ack_o while req high", 1, cmd_ack_o[q]);
    end else begin
      timed_out("a command ack");
    end
    cmd_req_i[q] = 1'b0;
    if (acked) begin
      next_cycle();
      check("cmd_ack_o after req fall", 0, cmd_ack_o[q]);
    end
    cnt = 0;
    while (cmd_ack_o[q] && cnt < Timeout) begin
      next_cycle();
      cnt++;
    end
    if (cmd_ack_o[q]) timed_out("a command ack to fall");
  endtask

  // Four-phase write that updates the model when the ack is seen
  task automatic write_word(input int port, input vid_t id, input vrf_addr_t addr,
                            input elem_t data);
    int      cnt;
    logic    acked;
    result_t res;
    res.id   = id;
    res.addr = addr;
    res.data = data;
    next_cycle();
    set_write(port, 1'b1, res);
    cnt = 0;
    do begin
      next_cycle();
      cnt++;
    end while (!wr_ack(port) && cnt < Timeout);
    acked = wr_ack(port);
    if (acked) begin
      model_mem[addr] = data;
      next_cycle();
      check("wr_ack_o while req high", 1, wr_ack(port));
    end else begin
      timed_out("a write ack");
    end
    set_write(port, 1'b0, res);
    if (acked) begin
      next_cycle();
      check("wr_ack_o after req fall", 0, wr_ack(port));
    end
    cnt = 0;
    while (wr_ack(port) && cnt < Timeout) begin
      next_cycle();
      cnt++;
    end
    if (wr_ack(port)) timed_out("a write ack to fall");
  endtask

  task automatic wait_drained(input int q);
    int cnt;
    cnt = 0;
    while (exp_wr[q] != exp_rd[q] && cnt < Timeout) begin
      next_cycle();
      cnt++;
    end
    if (exp_wr[q] != exp_rd[q]) timed_out($sformatf("queue %0d to drain", q));
  endtask

  // Reads stay in the lower half while the writers use the upper half
  task automatic reader_burst(input int q, input int n);
    for (int i = 0; i < n; i++) begin
      read_cmd(q, vrf_addr_t'(rand_below(16)), vlen_t'(1 + rand_below(16)), 1'b0, '0);
      wait_drained(q);
    end
  endtask

  task automatic writer_burst(input int port, input int n);
    for (int i = 0; i < n; i++) begin
      write_word(port, vid_t'(rand_below(4)), vrf_addr_t'(32 + rand_below(32)), rand_word());
    end
  endtask

  // Operand consumer that pops at random and compares against the FIFOs
  always @(posedge clk_i) begin
    #1;
    for (int q = 0; q < int'(NrQueues); q++) begin
      op_pop_i[q] = 1'b0;
      if (op_valid_o[q] && !pop_hold[q] && rand_below(100) < pop_pct[q]) begin
        if (exp_wr[q] == exp_rd[q]) begin
          value_errors++;
          $display("Queue %0d offered a word that no command asked for at %0t", q, $time);
        end else begin
          check($sformatf("op_data_o[%0d]", q), exp_data[q][exp_rd[q] % ExpSize],
                op_data_o[q]);
          exp_rd[q]++;
        end
        op_pop_i[q] = 1'b1;
      end
    end
  end

  initial begin
    vrf_addr_t base;
    value_errors   = 0;
    timeout_errors = 0;
    cmd_req_i      = '0;
    cmd_i          = '0;
    alu_wr_req_i   = 1'b0;
    alu_wr_i       = '0;
    ldu_wr_req_i   = 1'b0;
    ldu_wr_i       = '0;
    pop_hold       = '0;
    for (int q = 0; q < int'(NrQueues); q++) begin
      exp_wr[q]  = 0;
      exp_rd[q]  = 0;
      pop_pct[q] = 70;
    end
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    check("cmd_ack_o", '0, cmd_ack_o);
    check("alu_wr_ack_o", 0, alu_wr_ack_o);
    check("ldu_wr_ack_o", 0, ldu_wr_ack_o);
    check("op_valid_o", '0, op_valid_o);

    // Fill the whole file and read it back without hazards
    for (int a = 0; a < 64; a++) begin
      write_word(rand_below(2), vid_t'(rand_below(4)), vrf_addr_t'(a), rand_word());
    end
    for (int i = 0; i < 6; i++) begin
      read_cmd(i % 2, vrf_addr_t'(rand_below(64)), vlen_t'(1 + rand_below(16)), 1'b0, '0);
      wait_drained(i % 2);
    end

    // Everything at once with bank conflicts
    fork
      reader_burst(0, 4);
      reader_burst(1, 4);
      writer_burst(0, 12);
      writer_burst(1, 12);
    join
    read_cmd(0, vrf_addr_t'(32), vlen_t'(32), 1'b0, '0);
    wait_drained(0);

    // Consumer stalls long enough to fill the queue
    pop_hold[1] = 1'b1;
    read_cmd(1, vrf_addr_t'(rand_below(64)), vlen_t'(12), 1'b0, '0);
    repeat (40 + rand_below(40)) next_cycle();
    check("op_valid_o[1] during hold", 1, op_valid_o[1]);
    pop_hold[1] = 1'b0;
    wait_drained(1);

    // Dependent read paced by ldu writes of id 2
    pop_pct[0] = 100;
    base = vrf_addr_t'(rand_below(56));
    for (int i = 0; i < 8; i++) begin
      fresh[base + i] = model_mem[base + i] ^ (rand_word() | 32'h1);
    end
    read_cmd(0, base, vlen_t'(8), 1'b1, vid_t'(2));
    for (int i = 0; i < 8; i++) begin
      write_word(1, vid_t'(2), vrf_addr_t'(base + i), fresh[base + i]);
    end
    wait_drained(0);

    for (int q = 0; q < int'(NrQueues); q++) begin
      wait_drained(q);
    end
    $display("Value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: sources.f
src/vrf_pkg.sv
src/vrf_bank_arbiter.sv
src/operand_requester.sv
src/result_write_port.sv
src/vrf_banks.sv
src/operand_queue.sv
src/vrf_lane_top.sv
testbench/tb_vrf_lane_top.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the VRF lane testbench

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vrf_lane_top \
  -f sources.f -o sim_vrf_lane \
  && ./obj_dir/sim_vrf_lane > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
